// ==== build.f ====
+incdir+test
logic/dmix_pkg.sv
logic/polyphase_lane.sv
logic/i2s_dac_drv.sv
logic/dmix_core.sv
test/dmix_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := dmix_tb
FILELIST   := build.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
PASS_MSG   := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run, the exit status comes from the search for the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// ==== test/dmix_tb_tasks.svh ====
// Directed tests and LFSR sample source for the mixer playback testbench
`ifndef DMIX_TB_TASKS_SVH
`define DMIX_TB_TASKS_SVH

    logic [31:0] lfsr_state;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [dmix_pkg::SAMPLE_W-1:0] rand_bits(input int n);
        logic [dmix_pkg::SAMPLE_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[dmix_pkg::SAMPLE_W-2:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic test_reset_state();
        int err0;
        err0 = fail_cnt;
        check_low("dac_bck_o", dac_bck);
        check_low("dac_lrck_o", dac_lrck);
        check_low("dac_data_o", dac_data);
        idle_frames(3);
        if (rx_frames < 2) begin
            $display("Only %0d frames received after reset, two were due", rx_frames);
            fail_cnt = fail_cnt + 1;
        end
        report_test("reset_state", err0);
    endtask

    // Impulse walks all eight taps, one phase 0 and one phase 1 output per step
    task automatic test_impulse();
        int err0;
        err0 = fail_cnt;
        drive_frame(1'b1, 24'h100000, 1'b0, 24'h000000);
        idle_frames(1);
        repeat (8) begin
            drive_frame(1'b1, 24'h000000, 1'b0, 24'h000000);
            idle_frames(1);
        end
        idle_frames(2);
        report_test("impulse_response", err0);
    endtask

    task automatic test_channel_independence();
        int                            err0;
        logic                          sl;
        logic                          sr;
        logic [dmix_pkg::SAMPLE_W-1:0] vl;
        logic [dmix_pkg::SAMPLE_W-1:0] vr;
        err0 = fail_cnt;
        // Random strobes too, so both phases show up on both lanes
        repeat (48) begin
            sl = lfsr_step();
            vl = rand_bits(dmix_pkg::SAMPLE_W);
            sr = lfsr_step();
            vr = rand_bits(dmix_pkg::SAMPLE_W);
            drive_frame(sl, vl, sr, vr);
        end
        idle_frames(3);
        report_test("channel_independence", err0);
    endtask

    task automatic test_saturation();
        int                            err0;
        int                            hi0;
        int                            lo0;
        logic [7:0]                    sign_pat;
        logic                          flip;
        logic                          pos;
        logic [dmix_pkg::SAMPLE_W-1:0] vl;
        logic [dmix_pkg::SAMPLE_W-1:0] vr;
        err0 = fail_cnt;
        hi0  = sat_hi_cnt;
        lo0  = sat_lo_cnt;
        // Full scale with the signs of the phase 1 taps
        sign_pat = 8'b0101_1010;
        flip     = 1'b0;
        repeat (2) begin
            for (int i = 0; i < dmix_pkg::NUM_TAPS; i++) begin
                pos = sign_pat[i] ^ flip;
                vl  = pos ? 24'h7fffff : 24'h800000;
                vr  = pos ? 24'h800000 : 24'h7fffff;
                drive_frame(1'b1, vl, 1'b1, vr);
                idle_frames(1);
            end
            flip = 1'b1;
        end
        idle_frames(3);
        if (sat_hi_cnt == hi0 || sat_lo_cnt == lo0) begin
            $display("Output never reached both clamp limits during the saturation test");
            fail_cnt = fail_cnt + 1;
        end
        report_test("saturation", err0);
    endtask

    task automatic test_phase_hold();
        int                            err0;
        logic [dmix_pkg::SAMPLE_W-1:0] a;
        logic [dmix_pkg::SAMPLE_W-1:0] b;
        err0 = fail_cnt;
        a    = rand_bits(dmix_pkg::SAMPLE_W);
        b    = rand_bits(dmix_pkg::SAMPLE_W);
        drive_frame(1'b1, a, 1'b1, ~a);
        // Phase sticks at 1, same value every frame
        idle_frames(6);
        // Four strobes put b at tap 3 for the phase 0 output
        repeat (4) begin
            drive_frame(1'b1, b, 1'b1, ~b);
        end
        idle_frames(3);
        report_test("phase_hold", err0);
    endtask

`endif

// ==== test/dmix_tb.sv ====
// Mixer playback core testbench with I2S receiver, lane reference model and result summary
`timescale 1ns/1ps

module dmix_tb;

    // About 130 frames of 256 cycles, with margin
    localparam int TIMEOUT_CYCLES = 60000;

    logic              clk491520;
    logic              rst_ip;
    dmix_pkg::pcm_in_t left_i;
    dmix_pkg::pcm_in_t right_i;
    logic              dac_bck;
    logic              dac_lrck;
    logic              dac_data;

    // Reference lane state, index 0 is left and 1 is right
    logic signed [dmix_pkg::SAMPLE_W-1:0] m_hist [2][dmix_pkg::NUM_TAPS];
    int                                   m_phase [2];

    // One entry per frame
    logic [dmix_pkg::SAMPLE_W-1:0] exp_l [$];
    logic [dmix_pkg::SAMPLE_W-1:0] exp_r [$];
    logic [dmix_pkg::SAMPLE_W-1:0] rx_l [$];
    logic [dmix_pkg::SAMPLE_W-1:0] rx_r [$];

    // Model clamp direction per frame, 1 upper limit, -1 lower limit
    int clamp_l [$];
    int clamp_r [$];

    int pass_cnt;
    int fail_cnt;
    int rx_frames;
    int sat_hi_cnt;
    int sat_lo_cnt;
    int cycle_cnt;

    // Receiver state
    int                            rx_bit;
    logic                          rx_lr_last;
    logic [dmix_pkg::SAMPLE_W-1:0] rx_word;
    logic [dmix_pkg::SAMPLE_W-1:0] rx_left_word;

    dmix_core dut0 (
        .clk491520  (clk491520),
        .rst_ip     (rst_ip),
        .left_i     (left_i),
        .right_i    (right_i),
        .dac_bck_o  (dac_bck),
        .dac_lrck_o (dac_lrck),
        .dac_data_o (dac_data)
    );

    always #4 clk491520 = ~clk491520;

    always @(posedge clk491520) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Slot bit 0 is the I2S delay bit, bits 1 to 24 carry the word MSB first
    always @(posedge dac_bck) begin
        if (!rst_ip) begin
            if (dac_lrck !== rx_lr_last) begin
                rx_bit = 0;
            end else begin
                rx_bit = rx_bit + 1;
            end
            rx_lr_last = dac_lrck;
            if (rx_bit >= 1 && rx_bit <= dmix_pkg::SAMPLE_W) begin
                rx_word = {rx_word[dmix_pkg::SAMPLE_W-2:0], dac_data};
            end else if (dac_data !== 1'b0) begin
                $display("ERROR dac_data_o pad bit %0d: expected 0, got %h", rx_bit, dac_data);
                fail_cnt = fail_cnt + 1;
            end
            if (rx_bit == dmix_pkg::SAMPLE_W) begin
                if (!dac_lrck) begin
                    rx_left_word = rx_word;
                end else begin
                    rx_l.push_back(rx_left_word);
                    rx_r.push_back(rx_word);
                end
            end
        end
    end

    function automatic logic [dmix_pkg::SAMPLE_W-1:0] fir_out(input int ch,
                                                              output int clamp);
        longint                        acc;
        longint                        shifted;
        logic [dmix_pkg::SAMPLE_W-1:0] res;
        acc   = 0;
        clamp = 0;
        for (int k = 0; k < dmix_pkg::NUM_TAPS; k++) begin
            acc += longint'(dmix_pkg::FIR_COEF[m_phase[ch]][k]) * longint'(m_hist[ch][k]);
        end
        shifted = acc >>> dmix_pkg::COEF_FRAC;
        if (shifted > 64'sd8388607) begin
            res   = 24'h7fffff;
            clamp = 1;
        end else if (shifted < -64'sd8388608) begin
            res   = 24'h800000;
            clamp = -1;
        end else begin
            res = shifted[dmix_pkg::SAMPLE_W-1:0];
        end
        return res;
    endfunction

    task automatic model_strobe(input int ch, input logic [dmix_pkg::SAMPLE_W-1:0] v);
        for (int k = dmix_pkg::NUM_TAPS - 1; k > 0; k--) begin
            m_hist[ch][k] = m_hist[ch][k-1];
        end
        m_hist[ch][0] = v;
        m_phase[ch]   = 0;
    endtask

    // Result of the pop in one frame goes out in the next
    task automatic model_pop();
        int cl;
        int cr;
        exp_l.push_back(fir_out(0, cl));
        exp_r.push_back(fir_out(1, cr));
        clamp_l.push_back(cl);
        clamp_r.push_back(cr);
        for (int ch = 0; ch < 2; ch++) begin
            if (m_phase[ch] < dmix_pkg::NUM_PHASES - 1) begin
                m_phase[ch] = m_phase[ch] + 1;
            end
        end
    endtask

    always @(negedge dac_lrck) begin
        if (!rst_ip) begin
            model_pop();
        end
    end

    task automatic check_low(input string name, input logic val);
        if (val !== 1'b0) begin
            $display("ERROR %s after reset: expected 0, got %h", name, val);
            fail_cnt = fail_cnt + 1;
        end else begin
            pass_cnt = pass_cnt + 1;
        end
    endtask

    task automatic check_word(input string name, input logic [dmix_pkg::SAMPLE_W-1:0] exp,
                              input logic [dmix_pkg::SAMPLE_W-1:0] got);
        if (got !== exp) begin
            $display("ERROR %s frame %0d: expected %06h, got %06h", name, rx_frames, exp, got);
            fail_cnt = fail_cnt + 1;
        end else begin
            pass_cnt = pass_cnt + 1;
        end
    endtask

    task automatic compare_pending();
        logic [dmix_pkg::SAMPLE_W-1:0] got_l;
        logic [dmix_pkg::SAMPLE_W-1:0] got_r;
        int                            cl;
        int                            cr;
        while (rx_l.size() > 0 && exp_l.size() > 0) begin
            got_l = rx_l.pop_front();
            got_r = rx_r.pop_front();
            cl    = clamp_l.pop_front();
            cr    = clamp_r.pop_front();
            check_word("dac_data_o left slot", exp_l.pop_front(), got_l);
            check_word("dac_data_o right slot", exp_r.pop_front(), got_r);
            // Only clamped sums count, a full-scale sample passed through at phase 0 does not
            if ((cl > 0 && got_l == 24'h7fffff) || (cr > 0 && got_r == 24'h7fffff)) begin
                sat_hi_cnt = sat_hi_cnt + 1;
            end
            if ((cl < 0 && got_l == 24'h800000) || (cr < 0 && got_r == 24'h800000)) begin
                sat_lo_cnt = sat_lo_cnt + 1;
            end
            rx_frames = rx_frames + 1;
        end
        if (rx_l.size() > 0) begin
            $display("Frame %0d arrived before its expected value was known", rx_frames);
            fail_cnt = fail_cnt + 1;
            rx_l.delete();
            rx_r.delete();
        end
    endtask

    // Strobe at frame count 128, well away from the pop
    task automatic drive_frame(input logic sl, input logic [dmix_pkg::SAMPLE_W-1:0] vl,
                               input logic sr, input logic [dmix_pkg::SAMPLE_W-1:0] vr);
        @(posedge dac_lrck);
        @(negedge clk491520);
        left_i.strobe  = sl;
        left_i.sample  = vl;
        right_i.strobe = sr;
        right_i.sample = vr;
        if (sl) begin
            model_strobe(0, vl);
        end
        if (sr) begin
            model_strobe(1, vr);
        end
        @(negedge clk491520);
        left_i  = '0;
        right_i = '0;
        compare_pending();
    endtask

    task automatic idle_frames(input int n);
        repeat (n) begin
            drive_frame(1'b0, 24'h000000, 1'b0, 24'h000000);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("Test %s done, %0d errors", name, fail_cnt - err0);
    endtask

    `include "dmix_tb_tasks.svh"

    initial begin
        clk491520    = 1'b0;
        rst_ip       = 1'b1;
        left_i       = '0;
        right_i      = '0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        rx_frames    = 0;
        sat_hi_cnt   = 0;
        sat_lo_cnt   = 0;
        cycle_cnt    = 0;
        rx_bit       = 0;
        rx_lr_last   = 1'b1;
        rx_word      = '0;
        rx_left_word = '0;
        lfsr_state   = 32'h702c_9297;
        for (int ch = 0; ch < 2; ch++) begin
            m_phase[ch] = 0;
            for (int k = 0; k < dmix_pkg::NUM_TAPS; k++) begin
                m_hist[ch][k] = '0;
            end
        end
        // Frame 0 shifts out the cleared register
        exp_l.push_back('0);
        exp_r.push_back('0);
        clamp_l.push_back(0);
        clamp_r.push_back(0);
        repeat (8) @(negedge clk491520);
        rst_ip = 1'b0;
        // Lanes are popped in the first cycle after reset as well
        model_pop();

        test_reset_state();
        test_impulse();
        test_channel_independence();
        test_saturation();
        test_phase_hold();

        // Two frames are still on their way at the last compare
        if (exp_l.size() != 2) begin
            $display("Serial output fell behind, %0d frames never arrived", exp_l.size() - 2);
            fail_cnt = fail_cnt + 1;
        end
        $display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/dmix_core.sv ====
// Mixer playback core: two interpolator lanes feeding one I2S DAC driver
`timescale 1ns/1ps

module dmix_core (
    input  logic              clk491520,
    input  logic              rst_ip,
    input  dmix_pkg::pcm_in_t left_i,
    input  dmix_pkg::pcm_in_t right_i,
    output logic              dac_bck_o,
    output logic              dac_lrck_o,
    output logic              dac_data_o
);

    // Bit 0 left lane, bit 1 right lane
    logic [1:0] pop;

    dmix_pkg::pcm_out_t lane_l_out;
    dmix_pkg::pcm_out_t lane_r_out;

    polyphase_lane lane_l (
        .clk491520 (clk491520),
        .rst_ip    (rst_ip),
        .pcm_i     (left_i),
        .pop_i     (pop[0]),
        .pcm_o     (lane_l_out)
    );

    polyphase_lane lane_r (
        .clk491520 (clk491520),
        .rst_ip    (rst_ip),
        .pcm_i     (right_i),
        .pop_i     (pop[1]),
        .pcm_o     (lane_r_out)
    );

    i2s_dac_drv dac0 (
        .clk491520 (clk491520),
        .rst_ip    (rst_ip),
        .pop_o     (pop),
        .left_i    (lane_l_out),
        .right_i   (lane_r_out),
        .bck_o     (dac_bck_o),
        .lrck_o    (dac_lrck_o),
        .data_o    (dac_data_o)
    );

endmodule

// ==== logic/i2s_dac_drv.sv ====
// I2S DAC driver: bit and word clocks, per-frame lane requests, MSB-first serial data
`timescale 1ns/1ps

module i2s_dac_drv (
    input  logic               clk491520,
    input  logic               rst_ip,
    output logic [1:0]         pop_o,
    input  dmix_pkg::pcm_out_t left_i,
    input  dmix_pkg::pcm_out_t right_i,
    output logic               bck_o,
    output logic               lrck_o,
    output logic               data_o
);

    // Frame position, one count per clock
    logic [dmix_pkg::FRAME_CNT_W-1:0] cnt_q;
    logic                             frame_end;
    logic                             bit_end;

    // Lane results waiting for the next frame
    logic [dmix_pkg::SAMPLE_W-1:0] hold_l_q;
    logic [dmix_pkg::SAMPLE_W-1:0] hold_r_q;

    // Both slots of the frame on the wire
    logic [dmix_pkg::FRAME_BITS-1:0] shift_q;

    assign frame_end = (cnt_q == dmix_pkg::FRAME_CNT_W'(dmix_pkg::CLKS_PER_FRAME - 1));
    assign bit_end   = (cnt_q[dmix_pkg::BCK_DIV_W-1:0] == '1);

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Both lanes are asked at count 0, from the first frame after reset on
    assign pop_o = {2{!rst_ip && (cnt_q == '0)}};

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            hold_l_q <= '0;
            hold_r_q <= '0;
        end else begin
            if (left_i.ack) begin
                hold_l_q <= left_i.sample;
            end
            if (right_i.ack) begin
                hold_r_q <= right_i.sample;
            end
        end
    end

    // Load at the frame boundary, shift on each falling bit clock
    // Leading zero gives the one-bit I2S delay after the word clock edge
    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            shift_q <= '0;
        end else if (frame_end) begin
            shift_q <= {1'b0, hold_l_q, {dmix_pkg::SLOT_PAD_W{1'b0}},
                        1'b0, hold_r_q, {dmix_pkg::SLOT_PAD_W{1'b0}}};
        end else if (bit_end) begin
            shift_q <= {shift_q[dmix_pkg::FRAME_BITS-2:0], 1'b0};
        end
    end

    // Bit clock low for the first half period, falls on multiples of four
    assign bck_o  = cnt_q[dmix_pkg::BCK_DIV_W-1];
    // Left slot in the lower half of the frame
    assign lrck_o = cnt_q[dmix_pkg::FRAME_CNT_W-1];
    assign data_o = shift_q[dmix_pkg::FRAME_BITS-1];

endmodule

// ==== logic/polyphase_lane.sv ====
// Polyphase lane: 2x FIR interpolation of one PCM channel with a serial multiply-accumulate
`timescale 1ns/1ps

module polyphase_lane (
    input  logic               clk491520,
    input  logic               rst_ip,
    input  dmix_pkg::pcm_in_t  pcm_i,
    input  logic               pop_i,
    output dmix_pkg::pcm_out_t pcm_o
);

    typedef logic [dmix_pkg::NUM_TAPS-1:0][dmix_pkg::SAMPLE_W-1:0] hist_t;

    // Live history and phase
    hist_t                        hist_q;
    hist_t                        hist_base;
    logic [dmix_pkg::PHASE_W-1:0] phase_q;
    logic [dmix_pkg::PHASE_W-1:0] phase_base;
    logic [dmix_pkg::PHASE_W-1:0] phase_adv;

    // Snapshot taken at pop
    hist_t                        work_hist;
    logic [dmix_pkg::PHASE_W-1:0] work_phase;

    // MAC sequencing
    logic                       run_q;
    logic                       fin_q;
    logic [dmix_pkg::TAP_W-1:0] tap_q;

    // MAC datapath
    logic signed [dmix_pkg::COEF_W-1:0]   coef_cur;
    logic signed [dmix_pkg::SAMPLE_W-1:0] smp_cur;
    logic signed [dmix_pkg::ACC_W-1:0]    coef_ext;
    logic signed [dmix_pkg::ACC_W-1:0]    smp_ext;
    logic signed [dmix_pkg::ACC_W-1:0]    prod;
    logic signed [dmix_pkg::ACC_W-1:0]    acc_q;
    logic signed [dmix_pkg::ACC_W-1:0]    acc_shr;
    logic signed [dmix_pkg::SAMPLE_W-1:0] result;

    // A strobe in the pop cycle is applied before the snapshot
    always_comb begin
        hist_base  = hist_q;
        phase_base = phase_q;
        if (pcm_i.strobe) begin
            hist_base  = {hist_q[dmix_pkg::NUM_TAPS-2:0], pcm_i.sample};
            phase_base = '0;
        end
    end

    // Phase stops at the last polyphase branch until the next strobe
    assign phase_adv = (phase_base == dmix_pkg::PHASE_W'(dmix_pkg::NUM_PHASES - 1))
                     ? phase_base
                     : phase_base + 1'b1;

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            hist_q  <= '0;
            phase_q <= '0;
        end else begin
            hist_q <= hist_base;
            if (pop_i) begin
                phase_q <= phase_adv;
            end else begin
                phase_q <= phase_base;
            end
        end
    end

    // Later strobes leave the running computation alone
    always_ff @(posedge clk491520) begin
        if (pop_i) begin
            work_hist  <= hist_base;
            work_phase <= phase_base;
        end
    end

    // Pop, then eight tap cycles, then one cycle to scale
    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            run_q <= 1'b0;
            fin_q <= 1'b0;
            tap_q <= '0;
        end else begin
            fin_q <= 1'b0;
            if (pop_i) begin
                run_q <= 1'b1;
                tap_q <= '0;
            end else if (run_q) begin
                tap_q <= tap_q + 1'b1;
                if (tap_q == dmix_pkg::TAP_W'(dmix_pkg::NUM_TAPS - 1)) begin
                    run_q <= 1'b0;
                    fin_q <= 1'b1;
                end
            end
        end
    end

    // Current tap product
    assign coef_cur = dmix_pkg::FIR_COEF[work_phase][tap_q];
    assign smp_cur  = work_hist[tap_q];
    assign coef_ext = {{(dmix_pkg::ACC_W - dmix_pkg::COEF_W){coef_cur[dmix_pkg::COEF_W-1]}},
                       coef_cur};
    assign smp_ext  = {{(dmix_pkg::ACC_W - dmix_pkg::SAMPLE_W){smp_cur[dmix_pkg::SAMPLE_W-1]}},
                       smp_cur};
    assign prod     = coef_ext * smp_ext;

    always_ff @(posedge clk491520) begin
        if (pop_i) begin
            acc_q <= '0;
        end else if (run_q) begin
            acc_q <= acc_q + prod;
        end
    end

    // Floor shift back to sample scale, then clamp
    assign acc_shr = acc_q >>> dmix_pkg::COEF_FRAC;

    always_comb begin
        if (acc_shr > dmix_pkg::SAT_MAX) begin
            result = dmix_pkg::SAT_MAX[dmix_pkg::SAMPLE_W-1:0];
        end else if (acc_shr < dmix_pkg::SAT_MIN) begin
            result = dmix_pkg::SAT_MIN[dmix_pkg::SAMPLE_W-1:0];
        end else begin
            result = acc_shr[dmix_pkg::SAMPLE_W-1:0];
        end
    end

    // Result and ack land 10 cycles after pop
    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            pcm_o <= '0;
        end else begin
            pcm_o.ack <= fin_q;
            if (fin_q) begin
                pcm_o.sample <= result;
            end
        end
    end

endmodule

// ==== logic/dmix_pkg.sv ====
// Mixer playback core shared widths, serial frame timing, FIR table and PCM types
package dmix_pkg;

    // Sample and coefficient formats
    localparam int SAMPLE_W  = 24;
    localparam int COEF_W    = 18;
    localparam int COEF_FRAC = 16;
    localparam int ACC_W     = 48;

    // Interpolator shape
    localparam int NUM_TAPS   = 8;
    localparam int NUM_PHASES = 2;
    localparam int TAP_W      = $clog2(NUM_TAPS);
    localparam int PHASE_W    = (NUM_PHASES > 1) ? $clog2(NUM_PHASES) : 1;

    // I2S frame timing in 49.152 MHz cycles
    localparam int CLKS_PER_BCK   = 4;
    localparam int SLOT_BITS      = 32;
    localparam int FRAME_BITS     = 2 * SLOT_BITS;
    localparam int CLKS_PER_FRAME = FRAME_BITS * CLKS_PER_BCK;
    localparam int BCK_DIV_W      = $clog2(CLKS_PER_BCK);
    localparam int FRAME_CNT_W    = $clog2(CLKS_PER_FRAME);

    // Zero bits after the sample word, one delay bit goes in front
    localparam int SLOT_PAD_W = SLOT_BITS - SAMPLE_W - 1;

    // Output clamp limits at accumulator width
    localparam logic signed [ACC_W-1:0] SAT_MAX =
        {{(ACC_W - SAMPLE_W + 1){1'b0}}, {(SAMPLE_W - 1){1'b1}}};
    localparam logic signed [ACC_W-1:0] SAT_MIN =
        {{(ACC_W - SAMPLE_W + 1){1'b1}}, {(SAMPLE_W - 1){1'b0}}};

    // Coefficients in Q2.16, 65536 is unity gain
    localparam logic signed [COEF_W-1:0] FIR_COEF [NUM_PHASES][NUM_TAPS] = '{
        // Phase 0 is a pure delay through tap 3
        '{
            18'sd0,
            18'sd0,
            18'sd0,
            18'sd65536,
            18'sd0,
            18'sd0,
            18'sd0,
            18'sd0
        },
        // Phase 1 half-band midpoint, taps sum to 65536
        '{
            -18'sd852,
            18'sd3473,
            -18'sd9372,
            18'sd39519,
            18'sd39519,
            -18'sd9372,
            18'sd3473,
            -18'sd852
        }
    };

    // One input channel, sample valid in the strobe cycle
    typedef struct packed {
        logic                       strobe;
        logic signed [SAMPLE_W-1:0] sample;
    } pcm_in_t;

    // One lane result, ack is a single-cycle pulse
    typedef struct packed {
        logic                       ack;
        logic signed [SAMPLE_W-1:0] sample;
    } pcm_out_t;

endpackage
